//--- compile.f
+incdir+design
design/ts_replace_pkg.sv
design/pid_filter_table.sv
design/replace_data_ram.sv
design/ts_packet_replacer.sv
design/ts_replace_top.sv
tb/ts_replace_asserts.sv
tb/ts_replace_tb.sv

//--- design/pid_filter_table.sv
`default_nettype none

`include "ts_replace_cfg.svh"

module pid_filter_table import ts_replace_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        pid_write,
	input  wire slot_t pid_slot,
	input  wire pid_t  pid_value,
	input  wire        pid_enable,
	output pid_t       rd_pid,
	output logic       rd_enable,
	input  wire pid_t  stream_pid,
	output logic       pid_hit
);

	pid_t slot_pid [`TS_PID_SLOTS];
	logic [`TS_PID_SLOTS-1:0] slot_en;
	logic [`TS_PID_SLOTS-1:0] slot_match;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `TS_PID_SLOTS; i++) begin
				slot_pid[i] <= '0;
			end
			slot_en <= '0;
		end else if (pid_write) begin
			slot_pid[pid_slot] <= pid_value; // the index width covers every slot.
			slot_en[pid_slot]  <= pid_enable;
		end
	end

	// host readback of the addressed slot.
	assign rd_pid    = slot_pid[pid_slot];
	assign rd_enable = slot_en[pid_slot];

	always_comb begin
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			slot_match[i] = slot_en[i] && (slot_pid[i] == stream_pid);
		end
	end

	assign pid_hit = |slot_match; // any enabled slot.

endmodule

`default_nettype wire

//--- design/replace_data_ram.sv
`default_nettype none

`include "ts_replace_cfg.svh"

module replace_data_ram import ts_replace_pkg::*; (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             data_write,
	input  wire word_addr_t data_index,
	input  wire word_t      data_word,
	input  wire             pump_request,
	output logic            pump_ready,
	output word_t           out_data,
	output word_addr_t      out_data_index,
	output logic            out_data_valid,
	input  wire byte_addr_t rd_byte_addr,
	output ts_byte_t        rd_byte
);

	localparam int LANE_W = $clog2(`TS_WORD_BYTES);

	word_t mem [STORE_WORDS];
	pump_state_t pump_state;
	word_addr_t pump_idx;
	logic pump_more;
	word_addr_t rd_word_idx;
	logic [LANE_W-1:0] rd_lane;
	word_t rd_word;

	always_ff @(posedge clk) begin
		if (data_write && (int'(data_index) < STORE_WORDS)) begin
			mem[data_index] <= data_word;
		end
	end

	// byte port for the replacer, lane 0 is the low byte.
	assign rd_word_idx = word_addr_t'(rd_byte_addr / `TS_WORD_BYTES);
	assign rd_lane = rd_byte_addr[LANE_W-1:0];
	assign rd_word = (int'(rd_word_idx) < STORE_WORDS) ? mem[rd_word_idx] : '0;
	assign rd_byte = rd_word[rd_lane*8 +: 8];

	assign pump_more = (pump_state == PUMP_RUN) && (int'(pump_idx) < STORE_WORDS);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pump_state     <= PUMP_IDLE;
			pump_ready     <= 1'b0;
			out_data_valid <= 1'b0;
			pump_idx       <= '0;
		end else begin
			out_data_valid <= pump_more;
			case (pump_state)
				PUMP_IDLE: begin
					if (pump_request) begin
						pump_ready <= 1'b0;
						pump_idx   <= '0;
						pump_state <= PUMP_RUN;
					end
				end
				PUMP_RUN: begin
					if (pump_more) begin
						pump_idx <= pump_idx + 1'b1;
					end else begin
						pump_ready <= 1'b1; // whole store sent.
						pump_state <= PUMP_IDLE;
					end
				end
				default: pump_state <= PUMP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pump_more) begin
			out_data       <= mem[pump_idx];
			out_data_index <= pump_idx;
		end
	end

endmodule

`default_nettype wire

//--- design/ts_packet_replacer.sv
`default_nettype none

`include "ts_replace_cfg.svh"

module ts_packet_replacer import ts_replace_pkg::*; (
	input  wire             clk,
	input  wire             rst_n,
	input  wire ts_byte_t   mpeg_data,
	input  wire             mpeg_valid,
	input  wire             mpeg_sync,
	input  wire             match_enable,
	input  wire             bypass,
	output pid_t            stream_pid,
	input  wire             pid_hit,
	output byte_addr_t      rd_byte_addr,
	input  wire ts_byte_t   rd_byte,
	output ts_byte_t        ts_out,
	output logic            ts_out_valid,
	output logic            ts_out_sync,
	output logic            matched_state
);

	localparam byte_addr_t LAST_OFFSET = byte_addr_t'(`TS_PACKET_BYTES - 1);

	ts_byte_t data_d1;
	ts_byte_t data_d2;
	ts_byte_t data_d3;
	logic sync_d1;
	logic sync_d2;
	logic sync_d3;
	logic [1:0] fill_cnt;
	logic out_beat;
	logic pkt_start;
	logic pkt_match;
	logic in_packet;
	logic replace_now;
	group_t act_group;
	group_t next_group;
	byte_addr_t offset;

	always_ff @(posedge clk) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1  <= 1'b0;
			sync_d2  <= 1'b0;
			sync_d3  <= 1'b0;
			fill_cnt <= '0;
		end else if (mpeg_valid) begin
			sync_d1 <= mpeg_sync;
			sync_d2 <= sync_d1;
			sync_d3 <= sync_d2;
			if (fill_cnt != 2'd3) begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	// one output per accepted beat once the line holds three bytes.
	assign out_beat = mpeg_valid && (fill_cnt == 2'd3);

	// sync is at stage 2 while byte 2 sits on the input.
	assign stream_pid = {data_d1[4:0], mpeg_data};
	assign pkt_start = mpeg_valid && sync_d2 && (data_d2 == `TS_SYNC_BYTE);
	assign pkt_match = pkt_start && match_enable && pid_hit;

	assign rd_byte_addr = byte_addr_t'(act_group) * byte_addr_t'(`TS_PACKET_BYTES) + offset;
	assign replace_now = in_packet && !bypass;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_packet  <= 1'b0;
			offset     <= '0;
			act_group  <= '0;
			next_group <= '0;
		end else if (mpeg_valid) begin
			if (pkt_start) begin
				in_packet <= pkt_match;
				offset    <= '0;
				if (pkt_match) begin
					act_group  <= next_group;
					next_group <= (int'(next_group) == `TS_DATA_GROUPS - 1) ?
						group_t'(0) : group_t'(next_group + 1'b1);
				end
			end else if (in_packet) begin
				if (offset == LAST_OFFSET) begin
					in_packet <= 1'b0; // last stored byte goes out now.
				end
				offset <= offset + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ts_out_valid  <= 1'b0;
			ts_out_sync   <= 1'b0;
			matched_state <= 1'b0;
		end else begin
			ts_out_valid  <= out_beat;
			ts_out_sync   <= out_beat && sync_d3;
			matched_state <= out_beat && replace_now;
		end
	end

	always_ff @(posedge clk) begin
		if (out_beat) begin
			ts_out <= replace_now ? rd_byte : data_d3;
		end
	end

endmodule

`default_nettype wire

//--- design/ts_replace_cfg.svh
`ifndef TS_REPLACE_CFG_SVH
`define TS_REPLACE_CFG_SVH

// transport stream framing.
`define TS_PACKET_BYTES 188
`define TS_SYNC_BYTE    8'h47

// host data word, power of two bytes.
`define TS_WORD_BYTES   4

// table slots and stored replacement packets.
`define TS_PID_SLOTS    4
`define TS_DATA_GROUPS  2

`endif

//--- design/ts_replace_pkg.sv
`default_nettype none

`include "ts_replace_cfg.svh"

package ts_replace_pkg;

	localparam int GROUP_WORDS = `TS_PACKET_BYTES / `TS_WORD_BYTES; // 47 words per packet.
	localparam int STORE_WORDS = GROUP_WORDS * `TS_DATA_GROUPS;

	typedef logic [7:0] ts_byte_t;
	typedef logic [12:0] pid_t;
	typedef logic [`TS_WORD_BYTES*8-1:0] word_t;
	typedef logic [$clog2(STORE_WORDS)-1:0] word_addr_t;
	typedef logic [$clog2(`TS_PACKET_BYTES*`TS_DATA_GROUPS)-1:0] byte_addr_t;
	typedef logic [$clog2(`TS_PID_SLOTS)-1:0] slot_t;
	typedef logic [$clog2(`TS_DATA_GROUPS)-1:0] group_t;

	typedef enum logic {
		PUMP_IDLE,
		PUMP_RUN
	} pump_state_t;

endpackage

`default_nettype wire

//--- design/ts_replace_top.sv
`default_nettype none

module ts_replace_top import ts_replace_pkg::*; (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             pid_write,
	input  wire slot_t      pid_slot,
	input  wire pid_t       pid_value,
	input  wire             pid_enable,
	output pid_t            rd_pid,
	output logic            rd_enable,
	input  wire             data_write,
	input  wire word_addr_t data_index,
	input  wire word_t      data_word,
	input  wire             pump_request,
	output logic            pump_ready,
	output word_t           out_data,
	output word_addr_t      out_data_index,
	output logic            out_data_valid,
	input  wire ts_byte_t   mpeg_data,
	input  wire             mpeg_valid,
	input  wire             mpeg_sync,
	input  wire             match_enable,
	input  wire             bypass,
	output ts_byte_t        ts_out,
	output logic            ts_out_valid,
	output logic            ts_out_sync,
	output logic            matched_state
);

	pid_t stream_pid;
	logic pid_hit;
	byte_addr_t rd_byte_addr;
	ts_byte_t rd_byte;

	pid_filter_table u_pid_filter_table (
		.clk        (clk),
		.rst_n      (rst_n),
		.pid_write  (pid_write),
		.pid_slot   (pid_slot),
		.pid_value  (pid_value),
		.pid_enable (pid_enable),
		.rd_pid     (rd_pid),
		.rd_enable  (rd_enable),
		.stream_pid (stream_pid),
		.pid_hit    (pid_hit)
	);

	replace_data_ram u_replace_data_ram (
		.clk            (clk),
		.rst_n          (rst_n),
		.data_write     (data_write),
		.data_index     (data_index),
		.data_word      (data_word),
		.pump_request   (pump_request),
		.pump_ready     (pump_ready),
		.out_data       (out_data),
		.out_data_index (out_data_index),
		.out_data_valid (out_data_valid),
		.rd_byte_addr   (rd_byte_addr),
		.rd_byte        (rd_byte)
	);

	ts_packet_replacer u_ts_packet_replacer (
		.clk           (clk),
		.rst_n         (rst_n),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.match_enable  (match_enable),
		.bypass        (bypass),
		.stream_pid    (stream_pid),
		.pid_hit       (pid_hit),
		.rd_byte_addr  (rd_byte_addr),
		.rd_byte       (rd_byte),
		.ts_out        (ts_out),
		.ts_out_valid  (ts_out_valid),
		.ts_out_sync   (ts_out_sync),
		.matched_state (matched_state)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module ts_replace_tb -o ts_replace_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/ts_replace_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1

//--- tb/ts_replace_asserts.sv
`default_nettype none

module ts_replace_asserts import ts_replace_pkg::*; (
	input wire             clk,
	input wire             rst_n,
	input wire             mpeg_valid,
	input wire             ts_out_valid,
	input wire             matched_state,
	input wire             pump_ready,
	input wire             out_data_valid,
	input wire word_addr_t out_data_index
);

	timeunit 1ns;
	timeprecision 1ps;

	// an output byte needs a beat accepted on the edge before.
	a_out_after_beat: assert property (@(posedge clk) disable iff (!rst_n)
		ts_out_valid |-> $past(mpeg_valid))
		else $error("ts_out_valid without an accepted input beat");

	a_ready_low_in_pump: assert property (@(posedge clk) disable iff (!rst_n)
		out_data_valid |-> !pump_ready)
		else $error("pump_ready high while pump words are still out");

	a_pump_index_step: assert property (@(posedge clk) disable iff (!rst_n)
		out_data_valid && $past(out_data_valid) |->
			out_data_index == word_addr_t'($past(out_data_index) + 1'b1))
		else $error("out_data_index skipped between pump words");

	a_match_on_beat: assert property (@(posedge clk) disable iff (!rst_n)
		matched_state |-> ts_out_valid)
		else $error("matched_state without an output byte");

endmodule

bind ts_replace_top ts_replace_asserts u_ts_replace_asserts (
	.clk            (clk),
	.rst_n          (rst_n),
	.mpeg_valid     (mpeg_valid),
	.ts_out_valid   (ts_out_valid),
	.matched_state  (matched_state),
	.pump_ready     (pump_ready),
	.out_data_valid (out_data_valid),
	.out_data_index (out_data_index)
);

`default_nettype wire

//--- tb/ts_replace_tb.sv
`default_nettype none

`include "ts_replace_cfg.svh"

module ts_replace_tb import ts_replace_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PKT = `TS_PACKET_BYTES;
	localparam int STORE = PKT * `TS_DATA_GROUPS / `TS_WORD_BYTES;

	logic clk;
	logic rst_n;
	logic pid_write;
	slot_t pid_slot;
	pid_t pid_value;
	logic pid_enable;
	pid_t rd_pid;
	logic rd_enable;
	logic data_write;
	word_addr_t data_index;
	word_t data_word;
	logic pump_request;
	logic pump_ready;
	word_t out_data;
	word_addr_t out_data_index;
	logic out_data_valid;
	ts_byte_t mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic match_enable;
	logic bypass;
	ts_byte_t ts_out;
	logic ts_out_valid;
	logic ts_out_sync;
	logic matched_state;

	word_t words [STORE];
	pid_t shadow_pid [`TS_PID_SLOTS];
	logic shadow_en [`TS_PID_SLOTS];
	ts_byte_t hist_data [$];
	logic hist_sync [$];
	logic [9:0] expected [$]; // {matched_state, ts_out_sync, ts_out}.
	logic [9:0] observed [$];
	int sub_start; // stream index of the sync byte of the packet being replaced.
	int sub_group;
	int next_group;
	int errors;
	int tests;
	int unsigned seed_val;

	ts_replace_top u_ts_replace_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk) begin
		if (rst_n && ts_out_valid) begin
			observed.push_back({matched_state, ts_out_sync, ts_out});
		end
	end

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
			input logic [31:0] got);
		$display("Error at time %0t: %s expected %h got %h", $time, sig, exp, got);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("Error at time %0t: %s", $time, what);
		errors++;
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		$display("%s finished with %0d errors", name, errors - start_errors);
	endtask

	function automatic logic table_hit(input pid_t pid);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			if (shadow_en[i] && shadow_pid[i] == pid) hit = 1'b1;
		end
		return hit;
	endfunction

	// little-endian lanes, group g starts at byte g*188 of the store.
	function automatic ts_byte_t stored_byte(input int group, input int off);
		int addr;
		addr = group * PKT + off;
		return ts_byte_t'(words[addr / `TS_WORD_BYTES] >> (8 * (addr % `TS_WORD_BYTES)));
	endfunction

	task automatic model_beat(input ts_byte_t d, input logic s);
		int n;
		int j;
		ts_byte_t b1;
		hist_data.push_back(d);
		hist_sync.push_back(s);
		n = hist_data.size() - 1;
		if (n >= 3) begin
			j = n - 3; // this beat releases the byte three beats back.
			if (sub_start >= 0 && j >= sub_start && j < sub_start + PKT && !bypass) begin
				expected.push_back({1'b1, hist_sync[j], stored_byte(sub_group, j - sub_start)});
			end else begin
				expected.push_back({1'b0, hist_sync[j], hist_data[j]});
			end
		end
		// the decision falls when byte 2 of a packet is in.
		if (n >= 2 && hist_sync[n-2] && hist_data[n-2] == `TS_SYNC_BYTE) begin
			b1 = hist_data[n-1];
			if (match_enable && table_hit({b1[4:0], d})) begin
				sub_start = n - 2;
				sub_group = next_group;
				next_group = (next_group + 1) % `TS_DATA_GROUPS;
			end else begin
				sub_start = -1;
			end
		end
	endtask

	task automatic drive_beat(input ts_byte_t d, input logic s, input logic byp);
		@(negedge clk);
		mpeg_data = d;
		mpeg_sync = s;
		mpeg_valid = 1'b1;
		bypass = byp;
		model_beat(d, s);
	endtask

	task automatic idle_beat();
		@(negedge clk);
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		mpeg_data = 8'h00;
	endtask

	task automatic send_packet(input pid_t pid, input int max_gap, input int byp_lo,
			input int byp_hi);
		ts_byte_t b;
		int gap;
		for (int i = 0; i < PKT; i++) begin
			if (i == 0) b = `TS_SYNC_BYTE;
			else if (i == 1) b = {3'b010, pid[12:8]};
			else if (i == 2) b = pid[7:0];
			else b = ts_byte_t'($urandom);
			drive_beat(b, i == 0, i >= byp_lo && i < byp_hi);
			gap = int'($urandom_range(max_gap, 0));
			repeat (gap) idle_beat();
		end
	endtask

	task automatic check_stream(output int matched);
		int waited;
		logic [9:0] e;
		logic [9:0] o;
		idle_beat();
		bypass = 1'b0;
		waited = 0;
		matched = 0;
		while (observed.size() < expected.size() && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (observed.size() != expected.size()) begin
			report_problem($sformatf("stream gave %0d output bytes where %0d were due",
				observed.size(), expected.size()));
		end
		while (observed.size() > 0 && expected.size() > 0) begin
			e = expected.pop_front();
			o = observed.pop_front();
			if (o[7:0] != e[7:0]) report_mismatch("ts_out", 32'(e[7:0]), 32'(o[7:0]));
			if (o[8] != e[8]) report_mismatch("ts_out_sync", 32'(e[8]), 32'(o[8]));
			if (o[9] != e[9]) report_mismatch("matched_state", 32'(e[9]), 32'(o[9]));
			if (o[9]) matched++;
		end
		observed.delete();
		expected.delete();
	endtask

	task automatic write_slot(input slot_t slot, input pid_t value, input logic en);
		@(negedge clk);
		pid_write = 1'b1;
		pid_slot = slot;
		pid_value = value;
		pid_enable = en;
		shadow_pid[slot] = value;
		shadow_en[slot] = en;
		@(negedge clk);
		pid_write = 1'b0;
	endtask

	task automatic read_slot(input slot_t slot);
		@(negedge clk);
		pid_slot = slot;
		@(negedge clk);
		if (rd_pid != shadow_pid[slot]) begin
			report_mismatch("rd_pid", 32'(shadow_pid[slot]), 32'(rd_pid));
		end
		if (rd_enable != shadow_en[slot]) begin
			report_mismatch("rd_enable", 32'(shadow_en[slot]), 32'(rd_enable));
		end
	endtask

	task automatic write_word(input word_addr_t idx, input word_t w);
		@(negedge clk);
		data_write = 1'b1;
		data_index = idx;
		data_word = w;
		@(negedge clk);
		data_write = 1'b0;
	endtask

	task automatic test_pid_table();
		int start_errors;
		start_errors = errors;
		write_slot(2'd0, 13'h0100, 1'b1);
		write_slot(2'd1, 13'h1abc, 1'b0);
		write_slot(2'd2, 13'h0021, 1'b1);
		write_slot(2'd3, 13'h1fff, 1'b1);
		// a 2-bit index reaches only real slots, so try fields without the strobe.
		@(negedge clk);
		pid_value = 13'h0555;
		pid_enable = 1'b1;
		for (int i = 0; i < `TS_PID_SLOTS; i++) read_slot(slot_t'(i));
		report_test("pid table", start_errors);
	endtask

	task automatic test_store_pump();
		int start_errors;
		int count;
		int waited;
		start_errors = errors;
		for (int i = 0; i < STORE; i++) begin
			words[i] = $urandom;
			write_word(word_addr_t'(i), words[i]);
		end
		write_word(7'd94, 32'hdead_beef); // past the store.
		write_word(7'd127, 32'hdead_beef);
		if (pump_ready) report_problem("pump_ready is high before the first pump");
		@(negedge clk);
		pump_request = 1'b1;
		@(negedge clk);
		pump_request = 1'b0;
		count = 0;
		waited = 0;
		while (count < STORE && waited < 200) begin
			@(negedge clk);
			waited++;
			if (out_data_valid) begin
				if (out_data_index != word_addr_t'(count)) begin
					report_mismatch("out_data_index", 32'(count), 32'(out_data_index));
				end
				if (out_data != words[count]) report_mismatch("out_data", words[count], out_data);
				count++;
			end
		end
		if (count < STORE) report_problem("pump timed out before the last word");
		waited = 0;
		while (!pump_ready && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (!pump_ready) report_problem("pump_ready did not rise after the last word");
		report_test("store pump", start_errors);
	endtask

	task automatic test_pass_through();
		int start_errors;
		int matched;
		start_errors = errors;
		match_enable = 1'b1;
		send_packet(13'h1abc, 2, 0, 0); // slot 1 holds it disabled.
		send_packet(13'h0200, 2, 0, 0);
		send_packet(13'h0022, 1, 0, 0);
		check_stream(matched);
		if (matched != 0) report_problem("matched_state rose on a pass-through packet");
		report_test("pass through", start_errors);
	endtask

	task automatic test_replace();
		int start_errors;
		int matched;
		start_errors = errors;
		repeat (3) send_packet(13'h0100, 0, 0, 0);
		send_packet(13'h0200, 0, 0, 0);
		check_stream(matched);
		if (matched != 3 * PKT) report_mismatch("replaced byte count", 32'(3 * PKT), 32'(matched));
		report_test("replace", start_errors);
	endtask

	task automatic test_no_match();
		int start_errors;
		int matched;
		start_errors = errors;
		match_enable = 1'b0;
		send_packet(13'h0100, 0, 0, 0);
		idle_beat();
		match_enable = 1'b1;
		write_slot(2'd2, 13'h0021, 1'b0);
		send_packet(13'h0021, 0, 0, 0);
		send_packet(13'h0100, 0, 0, 0); // takes group 1, the one still due.
		send_packet(13'h0200, 0, 0, 0);
		check_stream(matched);
		if (matched != PKT) report_mismatch("replaced byte count", 32'(PKT), 32'(matched));
		report_test("no match", start_errors);
	endtask

	task automatic test_bypass();
		int start_errors;
		int matched;
		start_errors = errors;
		send_packet(13'h0100, 0, 50, 100);
		send_packet(13'h0200, 0, 0, 0);
		check_stream(matched);
		if (matched != PKT - 50) begin
			report_mismatch("replaced byte count", 32'(PKT - 50), 32'(matched));
		end
		report_test("bypass", start_errors);
	endtask

	initial begin
		seed_val = $urandom(32'h84df);
		rst_n = 1'b0;
		pid_write = 1'b0;
		pid_slot = '0;
		pid_value = '0;
		pid_enable = 1'b0;
		data_write = 1'b0;
		data_index = '0;
		data_word = '0;
		pump_request = 1'b0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		match_enable = 1'b0;
		bypass = 1'b0;
		sub_start = -1;
		sub_group = 0;
		next_group = 0;
		errors = 0;
		tests = 0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			shadow_pid[i] = '0;
			shadow_en[i] = 1'b0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_pid_table();
		test_store_pump();
		test_pass_through();
		test_replace();
		test_no_match();
		test_bypass();
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
